// ==== sim.f ====
+incdir+testbench
common/serial_cpu_pkg.sv
source/cpu_sequencer.sv
source/operand_regfile.sv
source/execute_unit.sv
source/serial_cpu_8bit.sv
testbench/tb_serial_cpu.sv

// ==== Bender.yml ====
package:
  name: serial_cpu_8bit

sources:
  - files:
      - common/serial_cpu_pkg.sv
      - source/cpu_sequencer.sv
      - source/operand_regfile.sv
      - source/execute_unit.sv
      - source/serial_cpu_8bit.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_serial_cpu.sv

// ==== testbench/cpu_ref_model.svh ====
/* instruction encoders and an instruction-level reference
   interpreter that runs imem against ref_dmem */

`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

function automatic serial_cpu_pkg::word_t enc_rrr(serial_cpu_pkg::opcode_t op,
        logic [2:0] d, logic [2:0] s, logic [2:0] t);
    return {op, d, 1'b0, s, 1'b0, t};
endfunction

function automatic serial_cpu_pkg::word_t enc_ri(serial_cpu_pkg::opcode_t op,
        logic [2:0] d, serial_cpu_pkg::byte_t imm);
    return {op, d, imm};
endfunction

function automatic serial_cpu_pkg::word_t enc_rv(serial_cpu_pkg::opcode_t op,
        logic [2:0] d, logic [2:0] s, logic [3:0] v);
    return {op, d, 1'b0, s, v};
endfunction

// returns the final status, leaves the final data memory in ref_dmem
function automatic logic [1:0] run_reference();
    serial_cpu_pkg::word_t   regs [8];
    serial_cpu_pkg::word_t   instr;
    serial_cpu_pkg::opcode_t op;
    serial_cpu_pkg::byte_t   imm;
    serial_cpu_pkg::pc_t     pc;
    serial_cpu_pkg::pc_t     addr;
    serial_cpu_pkg::pc_t     target;
    logic [16:0]             wide;
    logic [2:0]              f1;
    logic [2:0]              f2;
    logic [2:0]              f3;
    logic [3:0]              v3;
    logic                    z;
    logic                    n;
    logic                    c;
    logic                    wr;
    logic                    upd;
    logic                    taken;
    for (int i = 0; i < 8; i++)
        regs[i] = '0;
    {z, n, c} = 3'b000;
    pc = '0;
    for (int step = 0; step < 20000; step++)
    begin
        // word w sits low byte first at 2w
        instr = {imem[{pc, 1'b1}], imem[{pc, 1'b0}]};
        op = serial_cpu_pkg::opcode_t'(instr[15:11]);
        f1 = instr[10:8];
        f2 = instr[6:4];
        f3 = instr[2:0];
        v3 = instr[3:0];
        imm = instr[7:0];
        wr = 1'b1;
        upd = 1'b1;
        wide = '0;
        case (op)
            serial_cpu_pkg::ADD:  wide = {1'b0, regs[f2]} + {1'b0, regs[f3]};
            serial_cpu_pkg::ADDI: wide = {1'b0, regs[f1]} + {9'b0, imm};
            serial_cpu_pkg::LDIH: wide = {1'b0, regs[f1]} + {1'b0, imm, 8'h00};
            serial_cpu_pkg::SUB,
            serial_cpu_pkg::CMP:  wide = {1'b0, regs[f2]} - {1'b0, regs[f3]};
            serial_cpu_pkg::SUBI: wide = {1'b0, regs[f1]} - {9'b0, imm};
            serial_cpu_pkg::SUIH: wide = {1'b0, regs[f1]} - {1'b0, imm, 8'h00};
            serial_cpu_pkg::AND:  wide = {1'b0, regs[f2] & regs[f3]};
            serial_cpu_pkg::OR:   wide = {1'b0, regs[f2] | regs[f3]};
            serial_cpu_pkg::XOR:  wide = {1'b0, regs[f2] ^ regs[f3]};
            serial_cpu_pkg::SLL:  wide = {c, regs[f2] << v3};
            serial_cpu_pkg::SRL:  wide = {c, regs[f2] >> v3};
            serial_cpu_pkg::SET:
            begin
                wide = {9'b0, imm};
                upd = 1'b0;
            end
            default:
            begin
                wr = 1'b0;
                upd = 1'b0;
            end
        endcase
        if (op == serial_cpu_pkg::CMP)
            wr = 1'b0;
        addr = regs[f2][7:0] + v3;
        if (op == serial_cpu_pkg::STORE)
        begin
            ref_dmem[{addr, 1'b0}] = regs[f1][7:0];
            ref_dmem[{addr, 1'b1}] = regs[f1][15:8];
        end
        if (op == serial_cpu_pkg::LOAD)
            regs[f1] = {ref_dmem[{addr, 1'b1}], ref_dmem[{addr, 1'b0}]};
        // branches read the flags left by earlier instructions
        target = (op == serial_cpu_pkg::JUMP) ? imm : regs[f1][7:0] + imm;
        case (op)
            serial_cpu_pkg::JUMP,
            serial_cpu_pkg::JMPR: taken = 1'b1;
            serial_cpu_pkg::BZ:   taken = z;
            serial_cpu_pkg::BNZ:  taken = !z;
            serial_cpu_pkg::BN:   taken = n;
            serial_cpu_pkg::BNN:  taken = !n;
            serial_cpu_pkg::BC:   taken = c;
            serial_cpu_pkg::BNC:  taken = !c;
            default:              taken = 1'b0;
        endcase
        if (upd)
        begin
            z = (wide[15:0] == 16'h0000);
            n = wide[15];
            c = wide[16];
        end
        if (wr)
            regs[f1] = wide[15:0];
        if (taken)
            pc = target;
        else if (op == serial_cpu_pkg::HALT)
            return serial_cpu_pkg::status_halt;
        else if (pc == 8'hFF)
            return serial_cpu_pkg::status_end;
        else
            pc = pc + 8'd1;
    end
    return serial_cpu_pkg::status_run;
endfunction

`endif

// ==== testbench/tb_serial_cpu.sv ====
/* testbench for serial_cpu_8bit: memory models, directed and
   random programs, compare process against the reference model */

`timescale 1ns/10ps

module tb_serial_cpu;

    logic                    clk;
    logic                    rst_n;
    logic                    start;
    serial_cpu_pkg::byte_t   i_data;
    serial_cpu_pkg::byte_t   d_rdata;
    serial_cpu_pkg::byte_t   d_wdata;
    logic [8:0]              i_addr;
    logic [8:0]              d_addr;
    logic                    d_we;
    logic                    busy;
    serial_cpu_pkg::status_t status;
    serial_cpu_pkg::byte_t   imem [512];
    serial_cpu_pkg::byte_t   dmem [512];
    serial_cpu_pkg::byte_t   ref_dmem [512];
    serial_cpu_pkg::word_t   prog [$];
    logic [1:0]              exp_status;
    logic                    compare_req;
    string                   test_name;
    integer                  seed;
    serial_cpu_pkg::opcode_t alu_ops [14] = '{serial_cpu_pkg::SET, serial_cpu_pkg::LDIH,
        serial_cpu_pkg::ADD, serial_cpu_pkg::ADDI, serial_cpu_pkg::SUB, serial_cpu_pkg::SUBI,
        serial_cpu_pkg::SUIH, serial_cpu_pkg::CMP, serial_cpu_pkg::AND, serial_cpu_pkg::OR,
        serial_cpu_pkg::XOR, serial_cpu_pkg::SLL, serial_cpu_pkg::SRL, serial_cpu_pkg::STORE};

    `include "cpu_ref_model.svh"

    serial_cpu_8bit serial_cpu_8bit_inst (
        .clk, .rst_n, .start, .i_data, .d_rdata, .i_addr, .d_addr,
        .d_wdata, .d_we, .busy, .status
    );

    always #4 clk = ~clk;

    // combinational reads, writes on the rising edge
    assign i_data  = imem[i_addr];
    assign d_rdata = dmem[d_addr];

    always @(posedge clk)
    begin
        if (d_we)
            dmem[d_addr] <= d_wdata;
    end

    task automatic check_value(input string name, input logic [15:0] expected,
            input logic [15:0] actual);
        if (expected !== actual)
        begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout in %s: %s never happened", test_name, what);
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    endtask

    // ----------------------------------------
    // compare process
    // ----------------------------------------
    always @(negedge clk)
    begin
        if (compare_req)
        begin
            check_value({test_name, " status"}, 16'(exp_status), 16'(status));
            for (int i = 0; i < 512; i++)
                check_value($sformatf("%s dmem[%0d]", test_name, i), 16'(ref_dmem[i]),
                            16'(dmem[i]));
            compare_req = 1'b0;
        end
    end

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // empty program of NOPs, data memory filled from the full address
    task automatic prepare_test();
        prog.delete();
        for (int a = 0; a < 512; a++)
        begin
            imem[a] = 8'h00;
            dmem[a] = 8'((a * 37) ^ (a >> 3) ^ 8'h5A);
        end
    endtask

    task automatic run_program(input string name);
        int cycles;
        test_name = name;
        foreach (prog[i])
        begin
            imem[2 * i]     = prog[i][7:0];
            imem[2 * i + 1] = prog[i][15:8];
        end
        ref_dmem = dmem;
        exp_status = run_reference();
        apply_reset();
        @(negedge clk);
        start = 1'b1;
        cycles = 0;
        while (!busy)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > 10)
                timeout_fail("busy rising after start");
        end
        start = 1'b0;
        cycles = 0;
        while (busy)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > 200000)
                timeout_fail("busy falling at end of program");
        end
        compare_req = 1'b1;
        cycles = 0;
        while (compare_req)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > 10)
                timeout_fail("compare finishing");
        end
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    task automatic random_tests();
        int k;
        for (int t = 0; t < 20; t++)
        begin
            prepare_test();
            for (int r = 1; r < 8; r++)
                prog.push_back(enc_ri(serial_cpu_pkg::SET, r, 8'($random(seed))));
            for (int i = 0; i < 24; i++)
            begin
                k = $unsigned($random(seed)) % 14;
                prog.push_back({alu_ops[k], 11'($random(seed))});
            end
            prog.push_back(enc_ri(serial_cpu_pkg::SET, 0, 8'h80));
            for (int r = 1; r < 8; r++)
                prog.push_back(enc_rv(serial_cpu_pkg::STORE, r, 0, r));
            prog.push_back(enc_ri(serial_cpu_pkg::HALT, 0, 0));
            run_program($sformatf("random %0d", t));
        end
    endtask

    initial
    begin
        clk = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        compare_req = 1'b0;
        seed = 39405;
        test_name = "reset";
        prepare_test();
        apply_reset();
        check_value("reset busy", 16'h0, 16'(busy));
        check_value("reset d_we", 16'h0, 16'(d_we));
        check_value("reset status", 16'(serial_cpu_pkg::status_run), 16'(status));

        prepare_test();
        prog = '{enc_ri(serial_cpu_pkg::SET, 1, 8'h34), enc_ri(serial_cpu_pkg::LDIH, 1, 8'h12),
            enc_ri(serial_cpu_pkg::SET, 2, 8'h0F), enc_rrr(serial_cpu_pkg::ADD, 3, 1, 2),
            enc_rv(serial_cpu_pkg::STORE, 3, 0, 0), enc_ri(serial_cpu_pkg::ADDI, 3, 8'h55),
            enc_rv(serial_cpu_pkg::STORE, 3, 0, 1), enc_rrr(serial_cpu_pkg::SUB, 4, 2, 1),
            enc_rv(serial_cpu_pkg::STORE, 4, 0, 2), enc_ri(serial_cpu_pkg::SUBI, 4, 8'h03),
            enc_ri(serial_cpu_pkg::SUIH, 4, 8'h01), enc_rv(serial_cpu_pkg::STORE, 4, 0, 3),
            enc_rrr(serial_cpu_pkg::AND, 5, 1, 2), enc_rv(serial_cpu_pkg::STORE, 5, 0, 4),
            enc_rrr(serial_cpu_pkg::OR, 6, 1, 2), enc_rv(serial_cpu_pkg::STORE, 6, 0, 5),
            enc_rrr(serial_cpu_pkg::XOR, 7, 1, 2), enc_rv(serial_cpu_pkg::STORE, 7, 0, 6),
            enc_rv(serial_cpu_pkg::SLL, 5, 1, 4), enc_rv(serial_cpu_pkg::STORE, 5, 0, 7),
            enc_rv(serial_cpu_pkg::SRL, 6, 1, 3), enc_rv(serial_cpu_pkg::STORE, 6, 0, 8),
            enc_ri(serial_cpu_pkg::HALT, 0, 0)};
        run_program("alu ops");

        prepare_test();
        prog = '{enc_ri(serial_cpu_pkg::SET, 1, 8'hCD), enc_ri(serial_cpu_pkg::LDIH, 1, 8'hAB),
            enc_ri(serial_cpu_pkg::SET, 2, 8'h10), enc_rv(serial_cpu_pkg::STORE, 1, 2, 3),
            enc_rv(serial_cpu_pkg::LOAD, 3, 2, 3), enc_ri(serial_cpu_pkg::ADDI, 3, 8'h01),
            enc_rv(serial_cpu_pkg::STORE, 3, 2, 5), enc_rv(serial_cpu_pkg::LOAD, 4, 0, 7),
            enc_rv(serial_cpu_pkg::STORE, 4, 2, 9), enc_ri(serial_cpu_pkg::HALT, 0, 0)};
        run_program("load store");

        // countdown loop, then each branch kind taken or not
        prepare_test();
        prog = '{enc_ri(serial_cpu_pkg::SET, 1, 8'd5), enc_ri(serial_cpu_pkg::SET, 2, 8'd1),
            enc_ri(serial_cpu_pkg::SET, 3, 8'h20), enc_ri(serial_cpu_pkg::ADDI, 4, 8'd3),
            enc_rrr(serial_cpu_pkg::SUB, 1, 1, 2), enc_ri(serial_cpu_pkg::BNZ, 0, 8'd3),
            enc_rv(serial_cpu_pkg::STORE, 4, 3, 0), enc_rrr(serial_cpu_pkg::CMP, 0, 1, 2),
            enc_ri(serial_cpu_pkg::BN, 0, 8'd10), enc_rv(serial_cpu_pkg::STORE, 2, 3, 1),
            enc_ri(serial_cpu_pkg::BC, 0, 8'd12), enc_rv(serial_cpu_pkg::STORE, 2, 3, 2),
            enc_ri(serial_cpu_pkg::BZ, 0, 8'd14), enc_rv(serial_cpu_pkg::STORE, 4, 3, 3),
            enc_ri(serial_cpu_pkg::BNN, 0, 8'd16), enc_rv(serial_cpu_pkg::STORE, 1, 3, 4),
            enc_ri(serial_cpu_pkg::BNC, 0, 8'd18), enc_ri(serial_cpu_pkg::SET, 5, 8'd20),
            enc_ri(serial_cpu_pkg::JUMP, 0, 8'd20), enc_rv(serial_cpu_pkg::STORE, 2, 3, 5),
            enc_ri(serial_cpu_pkg::SET, 6, 8'd23), enc_ri(serial_cpu_pkg::JMPR, 6, 8'd0),
            enc_rv(serial_cpu_pkg::STORE, 2, 3, 6), enc_rv(serial_cpu_pkg::STORE, 5, 3, 7),
            enc_ri(serial_cpu_pkg::HALT, 0, 0)};
        run_program("branches");

        // no HALT, so the core runs through pc 255
        prepare_test();
        prog = '{enc_ri(serial_cpu_pkg::SET, 1, 8'h77), enc_rv(serial_cpu_pkg::STORE, 1, 0, 2)};
        run_program("end of program");

        random_tests();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== source/serial_cpu_8bit.sv ====
/* top level of the byte-fed CPU core: sequencer, register file
   and execute unit joined to the instruction and data memory ports */

`timescale 1ns/10ps

module serial_cpu_8bit (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        start,
    input  serial_cpu_pkg::byte_t                       i_data,
    input  serial_cpu_pkg::byte_t                       d_rdata,
    output logic [serial_cpu_pkg::mem_addr_width-1:0]   i_addr,
    output logic [serial_cpu_pkg::mem_addr_width-1:0]   d_addr,
    output serial_cpu_pkg::byte_t                       d_wdata,
    output logic                                        d_we,
    output logic                                        busy,
    output serial_cpu_pkg::status_t                     status
);

    serial_cpu_pkg::opcode_t    opcode;
    serial_cpu_pkg::reg_index_t r1;
    serial_cpu_pkg::reg_index_t r2;
    serial_cpu_pkg::reg_index_t r3;
    logic [3:0]                 val3;
    serial_cpu_pkg::byte_t      imm8;
    logic                       latch_operands;
    logic                       execute_now;
    logic                       load_lo;
    logic                       load_hi;
    logic                       writeback;
    logic                       mem_phase_hi;
    logic                       branch_taken;
    serial_cpu_pkg::word_t      operand_a;
    serial_cpu_pkg::word_t      operand_b;
    serial_cpu_pkg::word_t      store_data;
    serial_cpu_pkg::word_t      result;

    cpu_sequencer cpu_sequencer_inst (
        .clk, .rst_n, .start, .branch_taken,
        .branch_target (result[serial_cpu_pkg::pc_width-1:0]),
        .i_data, .i_addr, .opcode, .r1, .r2, .r3, .val3, .imm8,
        .latch_operands, .execute_now, .load_lo, .load_hi, .writeback,
        .mem_phase_hi, .busy, .status
    );

    operand_regfile operand_regfile_inst (
        .clk, .rst_n, .opcode, .r1, .r2, .r3, .val3, .imm8,
        .latch_operands, .load_lo, .load_hi, .writeback, .result, .d_rdata,
        .operand_a, .operand_b, .store_data
    );

    execute_unit execute_unit_inst (
        .clk, .rst_n, .opcode, .operand_a, .operand_b, .store_data,
        .execute_now, .load_lo, .load_hi, .mem_phase_hi,
        .result, .branch_taken, .d_addr, .d_wdata, .d_we
    );

endmodule

// ==== source/execute_unit.sv ====
/* ALU with zero, negative and carry flags, result register,
   branch decision and the two-byte store to data memory */

`timescale 1ns/10ps

module execute_unit (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  serial_cpu_pkg::opcode_t                     opcode,
    input  serial_cpu_pkg::word_t                       operand_a,
    input  serial_cpu_pkg::word_t                       operand_b,
    input  serial_cpu_pkg::word_t                       store_data,
    input  logic                                        execute_now,
    input  logic                                        load_lo,
    input  logic                                        load_hi,
    input  logic                                        mem_phase_hi,
    output serial_cpu_pkg::word_t                       result,
    output logic                                        branch_taken,
    output logic [serial_cpu_pkg::mem_addr_width-1:0]   d_addr,
    output serial_cpu_pkg::byte_t                       d_wdata,
    output logic                                        d_we
);

    logic [serial_cpu_pkg::data_width:0] sum_full;
    logic [serial_cpu_pkg::data_width:0] diff_full;
    serial_cpu_pkg::word_t               alu_out;
    logic                                alu_carry;
    logic                                zero_flag;
    logic                                neg_flag;
    logic                                carry_flag;

    // extra top bit is carry out, or borrow for the difference
    assign sum_full  = {1'b0, operand_a} + {1'b0, operand_b};
    assign diff_full = {1'b0, operand_a} - {1'b0, operand_b};

    // ----------------------------------------
    // ALU
    // ----------------------------------------
    always_comb
    begin
        alu_out   = sum_full[serial_cpu_pkg::data_width-1:0];
        alu_carry = sum_full[serial_cpu_pkg::data_width];
        case (opcode)
            serial_cpu_pkg::AND:  {alu_carry, alu_out} = {1'b0, operand_a & operand_b};
            serial_cpu_pkg::OR:   {alu_carry, alu_out} = {1'b0, operand_a | operand_b};
            serial_cpu_pkg::XOR:  {alu_carry, alu_out} = {1'b0, operand_a ^ operand_b};
            serial_cpu_pkg::SLL:  {alu_carry, alu_out} = {carry_flag, operand_a << operand_b[3:0]};
            serial_cpu_pkg::SRL:  {alu_carry, alu_out} = {carry_flag, operand_a >> operand_b[3:0]};
            serial_cpu_pkg::SUB,
            serial_cpu_pkg::SUBI,
            serial_cpu_pkg::SUIH,
            serial_cpu_pkg::CMP:  {alu_carry, alu_out} = diff_full;
            serial_cpu_pkg::SET,
            serial_cpu_pkg::JUMP: alu_out = operand_b;
            default:              ;
        endcase
    end

    // result and flags at the end of EXECUTE
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            result     <= '0;
            zero_flag  <= 1'b0;
            neg_flag   <= 1'b0;
            carry_flag <= 1'b0;
        end
        else if (execute_now)
        begin
            result <= alu_out;
            if (serial_cpu_pkg::sets_flags(opcode))
            begin
                zero_flag  <= (alu_out == '0);
                neg_flag   <= alu_out[serial_cpu_pkg::data_width-1];
                carry_flag <= alu_carry;
            end
        end
    end

    // ----------------------------------------
    // branch and store
    // ----------------------------------------
    always_comb
    begin
        case (opcode)
            serial_cpu_pkg::JUMP,
            serial_cpu_pkg::JMPR: branch_taken = 1'b1;
            serial_cpu_pkg::BZ:   branch_taken = zero_flag;
            serial_cpu_pkg::BNZ:  branch_taken = !zero_flag;
            serial_cpu_pkg::BN:   branch_taken = neg_flag;
            serial_cpu_pkg::BNN:  branch_taken = !neg_flag;
            serial_cpu_pkg::BC:   branch_taken = carry_flag;
            serial_cpu_pkg::BNC:  branch_taken = !carry_flag;
            default:              branch_taken = 1'b0;
        endcase
    end

    assign d_addr  = {result[serial_cpu_pkg::pc_width-1:0], mem_phase_hi};
    assign d_wdata = mem_phase_hi ? store_data[15:8] : store_data[7:0];
    assign d_we    = (opcode == serial_cpu_pkg::STORE) && (load_lo || load_hi);

    // a store writes the low byte, then the high byte in the next cycle
    a_store_pair: assert property (@(posedge clk) disable iff (!rst_n)
        d_we |-> (load_lo && !mem_phase_hi) or (mem_phase_hi && $past(d_we && load_lo)));

endmodule

// ==== source/operand_regfile.sv ====
/* eight general registers, operand latching in DECODE,
   byte-wise load writes and result write-back */

`timescale 1ns/10ps

module operand_regfile (
    input  logic                        clk,
    input  logic                        rst_n,
    input  serial_cpu_pkg::opcode_t     opcode,
    input  serial_cpu_pkg::reg_index_t  r1,
    input  serial_cpu_pkg::reg_index_t  r2,
    input  serial_cpu_pkg::reg_index_t  r3,
    input  logic [3:0]                  val3,
    input  serial_cpu_pkg::byte_t       imm8,
    input  logic                        latch_operands,
    input  logic                        load_lo,
    input  logic                        load_hi,
    input  logic                        writeback,
    input  serial_cpu_pkg::word_t       result,
    input  serial_cpu_pkg::byte_t       d_rdata,
    output serial_cpu_pkg::word_t       operand_a,
    output serial_cpu_pkg::word_t       operand_b,
    output serial_cpu_pkg::word_t       store_data
);

    serial_cpu_pkg::word_t regs [serial_cpu_pkg::reg_count];
    logic                  is_load;

    assign is_load = (opcode == serial_cpu_pkg::LOAD);

    // ----------------------------------------
    // register writes
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < serial_cpu_pkg::reg_count; i++)
                regs[i] <= '0;
        end
        else if (load_lo && is_load)
            regs[r1][7:0] <= d_rdata;
        else if (load_hi && is_load)
            regs[r1][15:8] <= d_rdata;
        else if (writeback && serial_cpu_pkg::writes_register(opcode))
            regs[r1] <= result;
    end

    // ----------------------------------------
    // operand latch
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (latch_operands)
        begin
            // JUMP and the no-operand opcodes see zero on the a side
            if (serial_cpu_pkg::a_from_r1(opcode))
                operand_a <= regs[r1];
            else if (serial_cpu_pkg::a_from_r2(opcode))
                operand_a <= regs[r2];
            else
                operand_a <= '0;

            if (serial_cpu_pkg::b_from_r3(opcode))
                operand_b <= regs[r3];
            else if (serial_cpu_pkg::b_from_val3(opcode))
                operand_b <= serial_cpu_pkg::word_t'(val3);
            else if (serial_cpu_pkg::b_from_imm8(opcode))
                operand_b <= serial_cpu_pkg::word_t'(imm8);
            else if (serial_cpu_pkg::b_from_imm8_high(opcode))
                operand_b <= {imm8, 8'h00};
            else
                operand_b <= '0;

            store_data <= regs[r1];
        end
    end

    // a load fills both bytes before its write-back phase
    a_load_order: assert property (@(posedge clk) disable iff (!rst_n)
        load_lo |-> !writeback ##1 (load_hi && !writeback) ##1 writeback);

endmodule

// ==== source/cpu_sequencer.sv ====
/* control FSM, program counter, instruction register,
   phase strobes and instruction byte address */

`timescale 1ns/10ps

module cpu_sequencer (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        start,
    input  logic                                        branch_taken,
    input  serial_cpu_pkg::pc_t                         branch_target,
    input  serial_cpu_pkg::byte_t                       i_data,
    output logic [serial_cpu_pkg::mem_addr_width-1:0]   i_addr,
    output serial_cpu_pkg::opcode_t                     opcode,
    output serial_cpu_pkg::reg_index_t                  r1,
    output serial_cpu_pkg::reg_index_t                  r2,
    output serial_cpu_pkg::reg_index_t                  r3,
    output logic [3:0]                                  val3,
    output serial_cpu_pkg::byte_t                       imm8,
    output logic                                        latch_operands,
    output logic                                        execute_now,
    output logic                                        load_lo,
    output logic                                        load_hi,
    output logic                                        writeback,
    output logic                                        mem_phase_hi,
    output logic                                        busy,
    output serial_cpu_pkg::status_t                     status
);

    serial_cpu_pkg::cpu_state_t state;
    serial_cpu_pkg::cpu_state_t next_state;
    serial_cpu_pkg::word_t      ir;
    serial_cpu_pkg::pc_t        pc;
    logic                       run_done;

    // HALT, or falling off the last word without a branch
    assign run_done = (opcode == serial_cpu_pkg::HALT) || (!branch_taken && (pc == '1));

    // ----------------------------------------
    // state machine
    // ----------------------------------------
    always_comb
    begin
        next_state = state;
        case (state)
            serial_cpu_pkg::IDLE:      if (start) next_state = serial_cpu_pkg::FETCH_HI;
            serial_cpu_pkg::FETCH_HI:  next_state = serial_cpu_pkg::FETCH_LO;
            serial_cpu_pkg::FETCH_LO:  next_state = serial_cpu_pkg::DECODE;
            serial_cpu_pkg::DECODE:    next_state = serial_cpu_pkg::EXECUTE;
            serial_cpu_pkg::EXECUTE:   next_state = serial_cpu_pkg::MEM_LO;
            serial_cpu_pkg::MEM_LO:    next_state = serial_cpu_pkg::MEM_HI;
            serial_cpu_pkg::MEM_HI:    next_state = serial_cpu_pkg::WRITEBACK;
            serial_cpu_pkg::WRITEBACK:
                next_state = run_done ? serial_cpu_pkg::IDLE : serial_cpu_pkg::FETCH_HI;
            default:                   next_state = serial_cpu_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= serial_cpu_pkg::IDLE;
        else
            state <= next_state;
    end

    // instruction register, high byte first
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ir <= '0;
        else if (state == serial_cpu_pkg::FETCH_HI)
            ir[15:8] <= i_data;
        else if (state == serial_cpu_pkg::FETCH_LO)
            ir[7:0] <= i_data;
    end

    // pc and run status
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc     <= '0;
            status <= serial_cpu_pkg::status_run;
        end
        else if (state == serial_cpu_pkg::IDLE && start)
        begin
            pc     <= '0;
            status <= serial_cpu_pkg::status_run;
        end
        else if (state == serial_cpu_pkg::WRITEBACK)
        begin
            if (branch_taken)
                pc <= branch_target;
            else if (opcode == serial_cpu_pkg::HALT)
                status <= serial_cpu_pkg::status_halt;
            else if (pc == '1)
                status <= serial_cpu_pkg::status_end;
            else
                pc <= pc + 1'b1;
        end
    end

    // ----------------------------------------
    // decoded fields and strobes
    // ----------------------------------------
    assign opcode = serial_cpu_pkg::opcode_t'(ir[serial_cpu_pkg::op_msb:serial_cpu_pkg::op_lsb]);
    assign r1     = ir[serial_cpu_pkg::r1_msb:serial_cpu_pkg::r1_lsb];
    assign r2     = ir[serial_cpu_pkg::r2_msb:serial_cpu_pkg::r2_lsb];
    assign r3     = ir[serial_cpu_pkg::r3_msb:serial_cpu_pkg::r3_lsb];
    assign val3   = ir[serial_cpu_pkg::val3_msb:serial_cpu_pkg::val3_lsb];
    assign imm8   = ir[serial_cpu_pkg::imm8_msb:serial_cpu_pkg::imm8_lsb];

    // byte-select bit is 1 only while fetching the high byte
    assign i_addr = {pc, state == serial_cpu_pkg::FETCH_HI};

    assign latch_operands = (state == serial_cpu_pkg::DECODE);
    assign execute_now    = (state == serial_cpu_pkg::EXECUTE);
    assign load_lo        = (state == serial_cpu_pkg::MEM_LO);
    assign load_hi        = (state == serial_cpu_pkg::MEM_HI);
    assign mem_phase_hi   = (state == serial_cpu_pkg::MEM_HI);
    assign writeback      = (state == serial_cpu_pkg::WRITEBACK);
    assign busy           = (state != serial_cpu_pkg::IDLE);

    // a taken branch moves pc, so the run must go on with the next fetch
    a_branch_continues: assert property (@(posedge clk) disable iff (!rst_n)
        (writeback && branch_taken) |=> (state == serial_cpu_pkg::FETCH_HI));

endmodule

// ==== common/serial_cpu_pkg.sv ====
/* widths, instruction field positions, opcode / state / status types
   and the opcode-class functions used for operand select and write-back */

package serial_cpu_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int data_width      = 16;
    localparam int byte_width      = 8;
    localparam int pc_width        = 8;
    localparam int mem_addr_width  = pc_width + 1;
    localparam int opcode_width    = 5;
    localparam int reg_count       = 8;
    localparam int reg_index_width = 3;

    // instruction fields
    localparam int op_msb    = 15;
    localparam int op_lsb    = 11;
    localparam int r1_msb    = 10;
    localparam int r1_lsb    = 8;
    localparam int r2_msb    = 6;
    localparam int r2_lsb    = 4;
    localparam int r3_msb    = 2;
    localparam int r3_lsb    = 0;
    localparam int val2_msb  = 7;
    localparam int val2_lsb  = 4;
    localparam int val3_msb  = val2_lsb - 1;
    localparam int val3_lsb  = 0;
    // imm8 is val2 and val3 read as one byte
    localparam int imm8_msb  = val2_msb;
    localparam int imm8_lsb  = val3_lsb;

    typedef logic [data_width-1:0]      word_t;
    typedef logic [byte_width-1:0]      byte_t;
    typedef logic [pc_width-1:0]        pc_t;
    typedef logic [reg_index_width-1:0] reg_index_t;

    typedef enum logic [opcode_width-1:0] {
        NOP, HALT, LOAD, STORE, LDIH, ADD, ADDI, SUB, SUBI, SUIH, CMP, AND, OR,
        XOR, SLL, SRL, SET, JUMP, JMPR, BZ, BNZ, BN, BNN, BC, BNC
    } opcode_t;

    typedef enum logic [3:0] {
        IDLE, FETCH_HI, FETCH_LO, DECODE, EXECUTE, MEM_LO, MEM_HI, WRITEBACK
    } cpu_state_t;

    typedef enum logic [1:0] {
        status_run  = 2'b00,
        status_halt = 2'b01,
        status_end  = 2'b10
    } status_t;

    // ----------------------------------------
    // opcode classes
    // ----------------------------------------
    function automatic logic sets_flags(opcode_t op);
        return op inside {LDIH, SUIH, ADD, ADDI, SUB, SUBI, CMP, AND, OR, XOR, SLL, SRL};
    endfunction

    // loads write r1 byte by byte, so they are not in this class
    function automatic logic writes_register(opcode_t op);
        return op inside {LDIH, ADD, ADDI, SUIH, SUB, SUBI, AND, OR, XOR, SLL, SRL, SET};
    endfunction

    function automatic logic a_from_r1(opcode_t op);
        return op inside {LDIH, SUIH, ADDI, SUBI, JMPR, BZ, BNZ, BN, BNN, BC, BNC, SET};
    endfunction

    function automatic logic a_from_r2(opcode_t op);
        return op inside {LOAD, STORE, ADD, SUB, CMP, AND, OR, XOR, SLL, SRL};
    endfunction

    function automatic logic b_from_r3(opcode_t op);
        return op inside {ADD, SUB, CMP, AND, OR, XOR};
    endfunction

    function automatic logic b_from_val3(opcode_t op);
        return op inside {LOAD, STORE, SLL, SRL};
    endfunction

    function automatic logic b_from_imm8(opcode_t op);
        return op inside {ADDI, SUBI, JUMP, JMPR, BZ, BNZ, BN, BNN, BC, BNC, SET};
    endfunction

    function automatic logic b_from_imm8_high(opcode_t op);
        return op inside {LDIH, SUIH};
    endfunction

endpackage
